// File: sim.f
uart_pkg.sv
uart_rx.sv
uart_tx.sv
uart_regs.sv
uart_periph.sv
uart_periph_props.sv
tb_uart_periph.sv

// File: Bender.yml
package:
  name: uart_periph

sources:
  - uart_pkg.sv
  - uart_rx.sv
  - uart_tx.sv
  - uart_regs.sv
  - uart_periph.sv
  - target: test
    files:
      - uart_periph_props.sv
      - tb_uart_periph.sv

// File: tb_uart_periph.sv
module tb_uart_periph import uart_pkg::*; ();

    localparam int tb_div         = 7;           // Divider for all serial tests.
    localparam int bit_cycles     = tb_div + 1;  // Clocks per serial bit.
    localparam int frame_bits     = 1 + payload_bits + stop_bits;
    // Twelve frames in all, plus room for bus polling.
    localparam int timeout_cycles = 12 * frame_bits * bit_cycles + 400;

    logic                    clk = 1'b0;
    logic                    resetn;
    uart_bus_req_t           bus;
    logic                    uart_rxd;
    logic [payload_bits-1:0] data_out;
    logic                    uart_txd;
    logic                    uart_rts;
    logic                    loopback;     // Feed txd straight back to rxd.
    logic                    serial_line;  // Line model driven by the testbench.
    logic [31:0]             lcg_state;
    int                      cycle_count = 0;

    assign uart_rxd = loopback ? uart_txd : serial_line;

    uart_periph u_dut (
        .clk      (clk),
        .resetn   (resetn),
        .bus      (bus),
        .uart_rxd (uart_rxd),
        .data_out (data_out),
        .uart_txd (uart_txd),
        .uart_rts (uart_rts)
    );

    always #20 clk = ~clk;  // 40 unit period.

    // --------------------
    // Failure reporting.

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input int expected, input int actual);
        report_failure($sformatf("Error in %s: expected 0x%0h, actual 0x%0h",
                                 name, expected, actual));
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            report_failure($sformatf("Run did not finish within %0d cycles.", timeout_cycles));
        end
    end

    // Bound assertions count their failures.
    always @(negedge clk) begin
        assert (u_dut.u_props.error_count == 0)
            else report_failure("A bound property assertion failed.");
    end

    // --------------------
    // Stimulus helpers.

    function automatic logic [7:0] draw_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // Fixed LCG step.
        return lcg_state[23:16];
    endfunction

    // One cycle strobe, taken at the next rising edge.
    task automatic bus_write(input uart_reg_e addr, input logic [7:0] wdata);
        bus.addr  = addr;
        bus.wdata = wdata;
        bus.wr    = 1'b1;
        @(negedge clk);
        bus.wr    = 1'b0;
    endtask

    task automatic bus_read(input uart_reg_e addr, output logic [7:0] rdata);
        bus.addr = addr;
        bus.rd   = 1'b1;
        #10 rdata = data_out;  // Mid low phase, well away from the edge.
        @(negedge clk);
        bus.rd   = 1'b0;
    endtask

    task automatic wait_status(input logic [7:0] mask, input logic [7:0] value);
        logic [7:0] status;
        bus_read(reg_status, status);
        while ((status & mask) != value) begin
            bus_read(reg_status, status);
        end
    endtask

    task automatic drive_frame(input logic [7:0] data, input logic stop_val);
        serial_line = 1'b0;  // Start bit.
        repeat (bit_cycles) @(negedge clk);
        for (int i = 0; i < payload_bits; i++) begin
            serial_line = data[i];  // LSB first.
            repeat (bit_cycles) @(negedge clk);
        end
        serial_line = stop_val;
        repeat (bit_cycles) @(negedge clk);
        serial_line = 1'b1;  // Line back to idle.
    endtask

    // --------------------
    // Test sequence.

    initial begin
        logic [7:0]            rdata;
        logic [7:0]            sent;
        logic [frame_bits-1:0] frame;
        resetn      = 1'b0;
        bus         = '0;
        loopback    = 1'b0;
        serial_line = 1'b1;
        lcg_state   = 32'h2933;
        repeat (3) @(negedge clk);
        resetn = 1'b1;

        bus_read(reg_status, rdata);  // Reset values.
        assert (rdata == 8'h00) else report_mismatch("reset_status", 0, rdata);
        bus_read(reg_div_lo, rdata);
        assert (rdata == div_reset[7:0])
            else report_mismatch("reset_div_lo", div_reset[7:0], rdata);
        bus_read(reg_div_hi, rdata);
        assert (rdata == 8'(div_reset >> 8))
            else report_mismatch("reset_div_hi", 8'(div_reset >> 8), rdata);
        assert (uart_txd == 1'b1) else report_mismatch("reset_txd", 1, uart_txd);
        assert (uart_rts == 1'b0) else report_mismatch("reset_rts", 0, uart_rts);

        bus_write(reg_div_hi, 8'h15);  // Nonzero high field, both engines idle.
        bus_read(reg_div_hi, rdata);
        assert (rdata == 8'h15) else report_mismatch("div_hi_field", 8'h15, rdata);
        bus_write(reg_div_lo, 8'(tb_div));  // Eight clocks per bit.
        bus_write(reg_div_hi, 8'(tb_div >> 8));
        bus_read(reg_div_lo, rdata);
        assert (rdata == 8'(tb_div)) else report_mismatch("div_lo_readback", tb_div, rdata);
        bus_read(reg_div_hi, rdata);
        assert (rdata == 8'(tb_div >> 8))
            else report_mismatch("div_hi_readback", 8'(tb_div >> 8), rdata);

        sent = draw_byte();
        bus_write(reg_data, sent);
        fork
            begin
                while (uart_txd) @(negedge clk);
                repeat (bit_cycles / 2 - 1) @(negedge clk);  // Middle of the start bit.
                frame[0] = uart_txd;
                for (int i = 1; i < frame_bits; i++) begin
                    repeat (bit_cycles) @(negedge clk);
                    frame[i] = uart_txd;
                end
            end
            begin
                repeat (2 * bit_cycles) @(negedge clk);
                bus_read(reg_status, rdata);
                assert (rdata[1] == 1'b1) else report_mismatch("tx_busy_flag", 1, rdata[1]);
                bus_write(reg_data, ~sent);  // Must be dropped.
            end
        join
        assert (frame == {1'b1, sent, 1'b0})
            else report_mismatch("tx_frame", {1'b1, sent, 1'b0}, frame);
        wait_status(8'h02, 8'h00);

        loopback = 1'b1;
        repeat (8) begin
            sent = draw_byte();
            wait_status(8'h02, 8'h00);  // Transmitter free again.
            bus_write(reg_data, sent);
            wait_status(8'h01, 8'h01);
            bus_read(reg_data, rdata);
            assert (rdata == sent) else report_mismatch("loopback_data", sent, rdata);
            bus_read(reg_status, rdata);
            assert (rdata[0] == 1'b0) else report_mismatch("loopback_valid_clear", 0, rdata[0]);
        end
        wait_status(8'h02, 8'h00);
        loopback = 1'b0;

        sent = draw_byte();
        drive_frame(sent, 1'b0);  // Low stop bit.
        repeat (2 * bit_cycles) @(negedge clk);
        bus_read(reg_status, rdata);
        assert (rdata[0] == 1'b0) else report_mismatch("framing_valid", 0, rdata[0]);
        assert (uart_rts == 1'b0) else report_mismatch("framing_rts", 0, uart_rts);

        sent = draw_byte();
        fork
            drive_frame(sent, 1'b1);
            begin
                repeat (5 * bit_cycles) @(negedge clk);  // Inside the data bits.
                assert (uart_rts == 1'b1) else report_mismatch("rts_receiving", 1, uart_rts);
            end
        join
        wait_status(8'h01, 8'h01);
        assert (uart_rts == 1'b1) else report_mismatch("rts_holding", 1, uart_rts);
        drive_frame(~sent, 1'b1);  // Arrives before the read.
        bus_read(reg_data, rdata);
        assert (rdata == sent) else report_mismatch("overrun_hold", sent, rdata);
        @(negedge clk);
        assert (uart_rts == 1'b0) else report_mismatch("rts_released", 0, uart_rts);

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: uart_periph_props.sv
module uart_periph_props (
    input logic clk,
    input logic resetn,
    input logic uart_rxd,    // Serial input as the receiver sees it.
    input logic uart_txd,
    input logic uart_rts,
    input logic tx_busy,
    input logic tx_start,
    input logic rx_valid,
    input logic rx_mid_bit   // Receiver at its sampling point.
);

    int error_count = 0;  // Failed assertions so far.

    // --------------------
    // Transmit side.

    txd_idle_high: assert property (@(posedge clk) disable iff (!resetn)
        !tx_busy |-> uart_txd)
    else begin
        error_count++;
        $error("uart_txd low while the transmitter is idle.");
    end

    // Start bit and busy flag both appear the cycle after launch.
    start_drops_txd: assert property (@(posedge clk) disable iff (!resetn)
        tx_start |=> tx_busy && !uart_txd)
    else begin
        error_count++;
        $error("Transmitter did not start a frame on the cycle after tx_start.");
    end

    // --------------------
    // Receive side.

    // The held byte appears one cycle after a high mid-bit sample of the stop bit.
    valid_needs_stop: assert property (@(posedge clk) disable iff (!resetn)
        $rose(rx_valid) |-> $past(rx_mid_bit && uart_rxd))
    else begin
        error_count++;
        $error("rx_valid rose without a high stop bit at mid-bit.");
    end

    rts_while_held: assert property (@(posedge clk) disable iff (!resetn)
        rx_valid |-> uart_rts)
    else begin
        error_count++;
        $error("uart_rts low while a received byte is held.");
    end

endmodule

bind uart_periph uart_periph_props u_props (
    .clk        (clk),
    .resetn     (resetn),
    .uart_rxd   (uart_rxd),
    .uart_txd   (uart_txd),
    .uart_rts   (uart_rts),
    .tx_busy    (tx_busy),
    .tx_start   (tx_start),
    .rx_valid   (rx_valid),
    .rx_mid_bit (u_rx.mid_bit)
);

// File: uart_periph.sv
module uart_periph import uart_pkg::*; (
    input  logic                    clk,
    input  logic                    resetn,
    input  uart_bus_req_t           bus,       // Peripheral bus request.
    input  logic                    uart_rxd,  // Serial input.
    output logic [payload_bits-1:0] data_out,  // Bus read data.
    output logic                    uart_txd,  // Serial output.
    output logic                    uart_rts   // Request to send, active low.
);

    logic [count_reg_len-1:0] baud_divider;  // Shared by both engines.
    logic                     tx_start;
    logic [payload_bits-1:0]  tx_data;
    logic                     tx_busy;
    logic                     rx_read;
    logic                     rx_valid;
    logic [payload_bits-1:0]  rx_data;

    // --------------------
    // Register block.

    uart_regs u_regs (
        .clk          (clk),
        .resetn       (resetn),
        .bus          (bus),
        .rx_valid     (rx_valid),
        .rx_data      (rx_data),
        .tx_busy      (tx_busy),
        .data_out     (data_out),
        .baud_divider (baud_divider),
        .tx_start     (tx_start),
        .tx_data      (tx_data),
        .rx_read      (rx_read)
    );

    // --------------------
    // Serial engines.

    uart_rx u_rx (
        .clk          (clk),
        .resetn       (resetn),
        .uart_rxd     (uart_rxd),
        .rx_read      (rx_read),
        .baud_divider (baud_divider),
        .uart_rts     (uart_rts),
        .rx_valid     (rx_valid),
        .rx_data      (rx_data)
    );

    uart_tx u_tx (
        .clk          (clk),
        .resetn       (resetn),
        .tx_start     (tx_start),
        .tx_data      (tx_data),
        .baud_divider (baud_divider),
        .uart_txd     (uart_txd),
        .tx_busy      (tx_busy)
    );

endmodule

// File: uart_regs.sv
module uart_regs import uart_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    input  uart_bus_req_t            bus,           // Peripheral bus request.
    input  logic                     rx_valid,      // Receiver holds a byte.
    input  logic [payload_bits-1:0]  rx_data,       // Held received byte.
    input  logic                     tx_busy,       // Transmitter sending.
    output logic [payload_bits-1:0]  data_out,      // Read data.
    output logic [count_reg_len-1:0] baud_divider,  // Bit period minus one.
    output logic                     tx_start,      // Launch pulse.
    output logic [payload_bits-1:0]  tx_data,       // Byte to send.
    output logic                     rx_read        // Received byte consumed.
);

    uart_reg_e reg_sel;
    logic      data_sel;

    // --------------------
    // Address decode.

    assign reg_sel  = uart_reg_e'(bus.addr);
    assign data_sel = reg_sel == reg_data;

    // A data write while busy is dropped.
    assign tx_start = bus.wr && data_sel && !tx_busy;
    assign tx_data  = bus.wdata;

    // A data read releases the held byte.
    assign rx_read  = bus.rd && data_sel;

    // --------------------
    // Divider register.

    always_ff @(posedge clk) begin
        if (!resetn) begin
            baud_divider <= div_reset;
        end else if (bus.wr) begin
            case (reg_sel)
                reg_div_lo: begin
                    baud_divider[payload_bits-1:0] <= bus.wdata;
                end
                reg_div_hi: begin
                    // Only the bits above the low byte exist.
                    baud_divider[count_reg_len-1:payload_bits] <=
                        bus.wdata[count_reg_len-payload_bits-1:0];
                end
                default: begin
                    baud_divider <= baud_divider;  // Other writes leave it.
                end
            endcase
        end
    end

    // --------------------
    // Read mux.

    always_comb begin
        case (reg_sel)
            reg_data: begin
                data_out = rx_data;
            end
            reg_status: begin
                data_out = {{(payload_bits - 2){1'b0}}, tx_busy, rx_valid};
            end
            reg_div_lo: begin
                data_out = baud_divider[payload_bits-1:0];
            end
            reg_div_hi: begin
                data_out = payload_bits'(baud_divider >> payload_bits);  // Zero extended.
            end
            default: begin
                data_out = '0;  // Unmapped addresses.
            end
        endcase
    end

endmodule

// File: uart_tx.sv
module uart_tx import uart_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     tx_start,      // Launch pulse.
    input  logic [payload_bits-1:0]  tx_data,       // Byte to send.
    input  logic [count_reg_len-1:0] baud_divider,  // Bit period minus one.
    output logic                     uart_txd,      // Serial output line.
    output logic                     tx_busy        // Frame in progress.
);

    tx_state_e                state;
    logic [count_reg_len-1:0] cycle_count;  // Cycles into the current bit.
    logic [bit_idx_bits-1:0]  bit_idx;      // Data or stop bit being sent.
    logic [payload_bits-1:0]  shift_reg;    // Bits not yet on the line.
    logic                     next_bit;

    assign next_bit = cycle_count >= baud_divider;
    assign tx_busy  = state != tx_st_idle;

    // --------------------
    // Frame sequencing.

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= tx_st_idle;
            cycle_count <= '0;
            bit_idx     <= '0;
            uart_txd    <= 1'b1;  // Line idles high.
        end else begin
            if (state == tx_st_idle || next_bit) begin
                cycle_count <= '0;
            end else begin
                cycle_count <= cycle_count + 1'b1;
            end
            case (state)
                tx_st_idle: begin
                    if (tx_start) begin
                        state    <= tx_st_start;
                        uart_txd <= 1'b0;  // Start bit.
                        bit_idx  <= '0;
                    end
                end
                tx_st_start: begin
                    if (next_bit) begin
                        state    <= tx_st_data;
                        uart_txd <= shift_reg[0];  // Bit 0 first.
                    end
                end
                tx_st_data: begin
                    if (next_bit && bit_idx == bit_idx_bits'(payload_bits - 1)) begin
                        state    <= tx_st_stop;
                        uart_txd <= 1'b1;
                        bit_idx  <= '0;
                    end else if (next_bit) begin
                        uart_txd <= shift_reg[0];
                        bit_idx  <= bit_idx + 1'b1;
                    end
                end
                tx_st_stop: begin
                    if (next_bit && bit_idx == bit_idx_bits'(stop_bits - 1)) begin
                        state <= tx_st_idle;  // Line stays high.
                    end else if (next_bit) begin
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                default: state <= tx_st_idle;
            endcase
        end
    end

    // Load on launch, then drop one bit per period.
    always_ff @(posedge clk) begin
        if (state == tx_st_idle && tx_start) begin
            shift_reg <= tx_data;
        end else if ((state == tx_st_start || state == tx_st_data) && next_bit) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

// File: uart_rx.sv
module uart_rx import uart_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     uart_rxd,      // Serial input line.
    input  logic                     rx_read,       // Held byte has been read.
    input  logic [count_reg_len-1:0] baud_divider,  // Bit period minus one.
    output logic                     uart_rts,      // Request to send, active low.
    output logic                     rx_valid,      // Byte available.
    output logic [payload_bits-1:0]  rx_data        // Received byte.
);

    rx_state_e                state;
    rx_state_e                state_next;
    logic [count_reg_len-1:0] cycle_count;  // Cycles into the current bit.
    logic [bit_idx_bits-1:0]  bit_idx;      // Data bit being received.
    logic                     bit_sample;   // Line value at mid-bit.
    logic [payload_bits-1:0]  shift_reg;    // Frame assembly, LSB first.
    logic                     next_bit;
    logic                     mid_bit;

    // --------------------
    // Bit timing.

    assign next_bit = cycle_count >= baud_divider;         // Last cycle of a bit.
    assign mid_bit  = cycle_count == (baud_divider >> 1);  // Sampling point.

    assign rx_valid = state == rx_st_ready;
    assign rx_data  = shift_reg;

    // --------------------
    // Next state.

    always_comb begin
        state_next = state;
        case (state)
            rx_st_idle: begin
                if (!uart_rxd) begin
                    state_next = rx_st_start;  // First low sample.
                end
            end
            rx_st_start: begin
                // A line back high at mid start bit was only a glitch.
                if (mid_bit && uart_rxd) begin
                    state_next = rx_st_idle;
                end else if (next_bit) begin
                    state_next = rx_st_recv;
                end
            end
            rx_st_recv: begin
                if (next_bit && bit_idx == bit_idx_bits'(payload_bits - 1)) begin
                    state_next = rx_st_stop;
                end
            end
            rx_st_stop: begin
                if (mid_bit) begin
                    state_next = uart_rxd ? rx_st_ready : rx_st_idle;  // Low stop drops it.
                end
            end
            rx_st_ready: begin
                if (rx_read) begin
                    state_next = rx_st_idle;
                end
            end
            default: state_next = rx_st_idle;
        endcase
    end

    // --------------------
    // Control registers.

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= rx_st_idle;
            cycle_count <= '0;
            bit_idx     <= '0;
            bit_sample  <= 1'b0;
            uart_rts    <= 1'b1;
        end else begin
            state <= state_next;
            // Counter only runs while a frame is on the line.
            if (next_bit || state == rx_st_idle || state == rx_st_ready) begin
                cycle_count <= '0;
            end else begin
                cycle_count <= cycle_count + 1'b1;
            end
            if (state != rx_st_recv) begin
                bit_idx <= '0;
            end else if (next_bit) begin
                bit_idx <= bit_idx + 1'b1;
            end
            if (mid_bit) begin
                bit_sample <= uart_rxd;
            end
            // Low only while nothing is being received or held.
            uart_rts <= !(state == rx_st_idle || state == rx_st_start);
        end
    end

    // Shift in each data bit at the end of its period.
    always_ff @(posedge clk) begin
        if (state == rx_st_recv && next_bit) begin
            shift_reg <= {bit_sample, shift_reg[payload_bits-1:1]};
        end
    end

endmodule

// File: uart_pkg.sv
package uart_pkg;

    // --------------------
    // Sizes.

    // Width of the baud divider and the bit period counters.
    localparam int count_reg_len = 13;  // Reaches 9600 baud at a 64 MHz clock.
    localparam int payload_bits  = 8;   // Data bits per frame.
    localparam int stop_bits     = 1;   // Stop bits per frame.
    localparam int reg_addr_bits = 4;   // Bus address width.

    // Width of the bit index used by both serial engines.
    localparam int bit_idx_bits  = $clog2(payload_bits);

    // Divider value after reset.
    localparam logic [count_reg_len-1:0] div_reset = 13'd16;

    // --------------------
    // Register map.

    typedef enum logic [reg_addr_bits-1:0] {
        reg_data   = 4'd0,  // Received byte on read, byte to send on write.
        reg_status = 4'd1,  // Bit 0 rx valid, bit 1 tx busy.
        reg_div_lo = 4'd2,  // Low byte of the divider.
        reg_div_hi = 4'd3   // High bits of the divider.
    } uart_reg_e;

    // --------------------
    // Engine states.

    typedef enum logic [2:0] {
        rx_st_idle,   // Waiting for a start bit.
        rx_st_start,  // Inside the start bit.
        rx_st_recv,   // Taking in data bits.
        rx_st_stop,   // Checking the stop bit.
        rx_st_ready   // Byte held until read.
    } rx_state_e;

    typedef enum logic [1:0] {
        tx_st_idle,   // Line high, ready for a byte.
        tx_st_start,  // Driving the start bit.
        tx_st_data,   // Shifting out data bits.
        tx_st_stop    // Driving the stop bits.
    } tx_state_e;

    // Peripheral bus request, one cycle per access.
    typedef struct packed {
        logic [reg_addr_bits-1:0] addr;   // Register address.
        logic [payload_bits-1:0]  wdata;  // Write data.
        logic                     wr;     // Write strobe.
        logic                     rd;     // Read strobe.
    } uart_bus_req_t;

endpackage
